// File: sim.f
+incdir+rtl
rtl/pe_data_pkg.sv
rtl/pe_ctrl_pkg.sv
rtl/pe_spad.sv
rtl/pe_ctrl.sv
rtl/pe_mac.sv
rtl/pe_result_port.sv
rtl/pe_top.sv
tb/tb_clkgen.sv
tb/tb_pe_top.sv

// File: run.sh
#!/bin/sh
# build the PE testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pe_top \
    -f sim.f -o tb_pe_top || exit 1

out=$(./obj_dir/tb_pe_top 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

// File: tb/tb_pe_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module tb_pe_top;

    localparam int num_jobs   = 40;
    localparam int max_wr     = 16;  // scratchpad writes before each job
    localparam int max_dly    = 15;  // handshake delays on the source and consumer side
    localparam int job_cycles = `PE_SPAD_DEPTH + `PE_DRAIN + 2 * max_dly + max_wr + 24;
    localparam int max_cycles = num_jobs * job_cycles + `PE_SPAD_DEPTH + 200;

    logic                    clk;
    logic                    rstn;
    logic                    wr_en;
    pe_data_pkg::spad_addr_t wr_addr;
    pe_data_pkg::act_t       wr_act;
    pe_data_pkg::wgt_t       wr_wgt;
    logic                    start_req;
    logic                    start_ack;
    pe_data_pkg::ksize_t     ksize;
    pe_data_pkg::psum_t      ipsum;
    logic                    busy;
    logic                    res_req;
    logic                    res_ack;
    pe_data_pkg::psum_t      res_data;

    pe_data_pkg::act_t act_m [`PE_SPAD_DEPTH];  // scratchpad mirror
    pe_data_pkg::wgt_t wgt_m [`PE_SPAD_DEPTH];
    logic [31:0]       rng;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

    pe_top uut (
        .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_addr(wr_addr), .wr_act(wr_act),
        .wr_wgt(wr_wgt), .start_req(start_req), .start_ack(start_ack), .ksize(ksize),
        .ipsum(ipsum), .busy(busy), .res_req(res_req), .res_ack(res_ack),
        .res_data(res_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // ipsum plus the dot product over a k x k window, wrapped to 24 bits
    function automatic pe_data_pkg::psum_t model_opsum(input int ks, input pe_data_pkg::psum_t ip);
        int                 k;
        logic signed [31:0] total;
        k = (ks > `PE_MAX_KERNEL) ? `PE_MAX_KERNEL : ks;
        total = ip;
        for (int i = 0; i < k * k; i++) begin
            total = total + act_m[i] * wgt_m[i];
        end
        return total[`PE_PSUM_W-1:0];
    endfunction

    function automatic string test_name(input int ks);
        if (ks == 0) return "zero_size";
        if (ks > `PE_MAX_KERNEL) return "clamp";
        return "dot_product";
    endfunction

    task automatic check_value(input string name, input pe_data_pkg::psum_t exp,
                               input pe_data_pkg::psum_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("ERROR at cycle %0d: %s", cycles, what);
        end
    endtask

    // one cycle, with a random write that must be dropped while busy
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r = rand32();
        wr_en   = busy && r[0];
        wr_addr = pe_data_pkg::spad_addr_t'(r[13:8]);
        wr_act  = r[23:16];
        wr_wgt  = r[31:24];
    endtask

    task automatic write_entry(input pe_data_pkg::spad_addr_t a);
        logic [31:0] r;
        @(negedge clk);
        r = rand32();
        wr_en   = 1'b1;
        wr_addr = a;
        wr_act  = (r[17:16] == 2'b00) ? 8'h80 : r[7:0];  // extremes now and then
        wr_wgt  = (r[19:18] == 2'b00) ? 8'h7f : r[15:8];
        if (!busy) begin
            act_m[a] = wr_act;
            wgt_m[a] = wr_wgt;
        end
    endtask

    task automatic start_job(input int ks, input pe_data_pkg::psum_t ip);
        int hold;
        next_cycle();
        expect_true(!start_ack, "start_ack high before start_req was raised");
        start_req = 1'b1;
        ksize     = pe_data_pkg::ksize_t'(ks);
        ipsum     = ip;
        do next_cycle(); while (!start_ack);
        expect_true(busy, "busy low when start_ack was seen");
        hold = rand32() % 4;
        repeat (hold) begin
            next_cycle();
            expect_true(start_ack, "start_ack fell while start_req was still high");
        end
        next_cycle();
        start_req = 1'b0;
        do next_cycle(); while (start_ack);
    endtask

    // drop the ack held from the previous job after a random delay
    task automatic release_ack();
        int dly;
        dly = rand32() % (max_dly + 1);
        repeat (dly) begin
            next_cycle();
            expect_true(!(res_ack && res_req), "new result presented before res_ack fell");
        end
        next_cycle();
        res_ack = 1'b0;
    endtask

    task automatic collect_result(input string name, input pe_data_pkg::psum_t exp);
        pe_data_pkg::psum_t got;
        int                 dly;
        while (!res_req) begin
            expect_true(busy, "busy dropped before the result was presented");
            next_cycle();
        end
        got = res_data;
        check_value(name, exp, got);
        dly = rand32() % (max_dly + 1);
        repeat (dly) begin
            next_cycle();
            expect_true(res_req, "res_req dropped before res_ack was raised");
            expect_true(res_data == got, "res_data changed while res_req was high");
        end
        next_cycle();
        res_ack = 1'b1;  // stays high into the next job
        do begin
            next_cycle();
            if (res_req) expect_true(res_data == got, "res_data changed before res_req fell");
        end while (res_req);
    endtask

    initial begin
        int                 nwr;
        int                 ks;
        pe_data_pkg::psum_t ip;
        pe_data_pkg::psum_t expected;
        logic [31:0]        r;
        rng       = 32'h257f4186;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_act    = '0;
        wr_wgt    = '0;
        start_req = 1'b0;
        ksize     = '0;
        ipsum     = '0;
        res_ack   = 1'b0;
        wait (rstn === 1'b1);
        @(negedge clk);
        expect_true(!start_ack && !res_req && !busy, "outputs not idle after reset");
        for (int a = 0; a < `PE_SPAD_DEPTH; a++) begin
            write_entry(pe_data_pkg::spad_addr_t'(a));
        end
        for (int j = 0; j < num_jobs; j++) begin
            nwr = rand32() % (max_wr + 1);
            repeat (nwr) write_entry(pe_data_pkg::spad_addr_t'(rand32()));
            ks = rand32() % 11;
            if (j == 0) ks = 0;
            if (j == 1) ks = 10;
            r = rand32();
            case (r[1:0])
                2'd0: ip = 24'h7fffff - 24'(r[13:2]);  // near the positive limit
                2'd1: ip = 24'h800000 + 24'(r[13:2]);  // near the negative limit
                default: ip = pe_data_pkg::psum_t'(rand32());
            endcase
            expected = model_opsum(ks, ip);
            start_job(ks, ip);
            release_ack();
            collect_result(test_name(ks), expected);
        end
        release_ack();
        repeat (4) begin
            next_cycle();
            expect_true(!res_req, "result presented with no job running");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    localparam time half_period  = 10ns;  // 20 ns clock
    localparam int  reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;  // release away from the active edge
    end

endmodule

`default_nettype wire

// File: rtl/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wr_en,
    input  pe_data_pkg::spad_addr_t wr_addr,
    input  pe_data_pkg::act_t       wr_act,
    input  pe_data_pkg::wgt_t       wr_wgt,
    input  logic                    start_req,
    output logic                    start_ack,
    input  pe_data_pkg::ksize_t     ksize,
    input  pe_data_pkg::psum_t      ipsum,
    output logic                    busy,
    output logic                    res_req,
    input  logic                    res_ack,
    output pe_data_pkg::psum_t      res_data
);

    logic                    spad_wr_en;
    logic                    rd_en;
    pe_data_pkg::spad_addr_t rd_addr;
    pe_data_pkg::act_t       rd_act;
    pe_data_pkg::wgt_t       rd_wgt;
    logic                    rd_valid;
    logic                    load_ipsum;
    pe_data_pkg::psum_t      job_ipsum;
    pe_data_pkg::psum_t      acc;
    logic                    post;
    logic                    free;
    pe_ctrl_pkg::pe_state_t  state;

    assign spad_wr_en = wr_en & ~busy;  // writes during a job are dropped

    pe_spad u_spad (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (spad_wr_en),
        .wr_addr  (wr_addr),
        .wr_act   (wr_act),
        .wr_wgt   (wr_wgt),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_act   (rd_act),
        .rd_wgt   (rd_wgt),
        .rd_valid (rd_valid)
    );

    pe_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .start_req  (start_req),
        .start_ack  (start_ack),
        .ksize      (ksize),
        .ipsum      (ipsum),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .load_ipsum (load_ipsum),
        .job_ipsum  (job_ipsum),
        .post       (post),
        .free       (free),
        .state      (state)
    );

    pe_mac u_mac (
        .clk        (clk),
        .rstn       (rstn),
        .load_ipsum (load_ipsum),
        .job_ipsum  (job_ipsum),
        .rd_act     (rd_act),
        .rd_wgt     (rd_wgt),
        .rd_valid   (rd_valid),
        .acc        (acc)
    );

    pe_result_port u_res (
        .clk      (clk),
        .rstn     (rstn),
        .post     (post),
        .acc      (acc),
        .free     (free),
        .res_req  (res_req),
        .res_data (res_data),
        .res_ack  (res_ack)
    );

    // posting needs st_opsum and an idle result handshake
    a_post_in_opsum: assert property (
        @(posedge clk) disable iff (!rstn)
        post |-> (state == pe_ctrl_pkg::st_opsum) && !res_req && !res_ack
    );

endmodule

`default_nettype wire

// File: rtl/pe_result_port.sv
`timescale 1ns/1ps
`default_nettype none

module pe_result_port (
    input  logic               clk,
    input  logic               rstn,
    input  logic               post,
    input  pe_data_pkg::psum_t acc,
    output logic               free,
    output logic               res_req,
    output pe_data_pkg::psum_t res_data,
    input  logic               res_ack
);

    // holding register, loaded once per job
    always_ff @(posedge clk) begin
        if (post) begin
            res_data <= acc;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_req <= 1'b0;
            free    <= 1'b1;
        end else begin
            if (post) begin
                res_req <= 1'b1;
                free    <= 1'b0;
            end else if (res_req && res_ack) begin
                res_req <= 1'b0;   // consumer took it
            end else if (!free && !res_req && !res_ack) begin
                free    <= 1'b1;   // ack has fallen, slot reusable
            end
        end
    end

    a_data_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        res_req && $past(res_req) |-> $stable(res_data)
    );

endmodule

`default_nettype wire

// File: rtl/pe_mac.sv
`timescale 1ns/1ps
`default_nettype none

module pe_mac (
    input  logic               clk,
    input  logic               rstn,
    input  logic               load_ipsum,
    input  pe_data_pkg::psum_t job_ipsum,
    input  pe_data_pkg::act_t  rd_act,
    input  pe_data_pkg::wgt_t  rd_wgt,
    input  logic               rd_valid,
    output pe_data_pkg::psum_t acc
);

    pe_data_pkg::prod_t prod_q;
    logic               prod_valid;   // stage-2 valid
    pe_data_pkg::psum_t prod_ext;

    // stage 1, signed 8x8 product
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            prod_q <= rd_act * rd_wgt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= rd_valid;
        end
    end

    assign prod_ext = pe_data_pkg::psum_t'(prod_q);  // sign extend to 24 bits

    // stage 2, overflow simply wraps
    always_ff @(posedge clk) begin
        if (load_ipsum) begin
            acc <= job_ipsum;
        end else if (prod_valid) begin
            acc <= acc + prod_ext;
        end
    end

    // ipsum load must come before any sample of the same job reaches stage 2
    a_load_vs_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        load_ipsum |-> !prod_valid
    );

endmodule

`default_nettype wire

// File: rtl/pe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module pe_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start_req,
    output logic                    start_ack,
    input  pe_data_pkg::ksize_t     ksize,
    input  pe_data_pkg::psum_t      ipsum,
    output logic                    busy,
    output logic                    rd_en,
    output pe_data_pkg::spad_addr_t rd_addr,
    output logic                    load_ipsum,
    output pe_data_pkg::psum_t      job_ipsum,
    output logic                    post,
    input  logic                    free,
    output pe_ctrl_pkg::pe_state_t  state
);

    pe_ctrl_pkg::pe_state_t  next_state;
    pe_data_pkg::ksize_t     k_clamp;
    logic [`PE_ADDR_W:0]     k_sq;        // clamped ksize squared, 0..64
    pe_data_pkg::spad_addr_t cnt;         // mac address in op, cycle count in drain
    logic                    accept;
    logic                    op_last;
    logic                    drain_last;

    assign k_clamp = (ksize > pe_data_pkg::ksize_t'(`PE_MAX_KERNEL)) ?
                     pe_data_pkg::ksize_t'(`PE_MAX_KERNEL) : ksize;

    // a fresh request only, ack from the last job must have dropped
    assign accept     = (state == pe_ctrl_pkg::st_idle) && start_req && !start_ack;
    assign op_last    = ({1'b0, cnt} == k_sq - 1'b1);
    assign drain_last = (cnt == pe_data_pkg::spad_addr_t'(`PE_DRAIN - 1));

    always_ff @(posedge clk) begin
        if (accept) begin
            job_ipsum <= ipsum;
            k_sq      <= (`PE_ADDR_W+1)'(k_clamp) * (`PE_ADDR_W+1)'(k_clamp);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= pe_ctrl_pkg::st_idle;
            cnt   <= '0;
        end else begin
            state <= next_state;
            if (state != next_state) begin
                cnt <= '0;  // every phase counts from zero
            end else if (state == pe_ctrl_pkg::st_op ||
                         state == pe_ctrl_pkg::st_drain) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // four-phase start: raise on accept, drop after req falls
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_ack <= 1'b0;
        end else if (accept) begin
            start_ack <= 1'b1;
        end else if (!start_req) begin
            start_ack <= 1'b0;
        end
    end

    always_comb begin
        case (state)
            pe_ctrl_pkg::st_idle: begin
                next_state = accept ? pe_ctrl_pkg::st_ipsum : pe_ctrl_pkg::st_idle;
            end
            pe_ctrl_pkg::st_ipsum: begin
                // zero-size job skips op and drain
                next_state = (k_sq == '0) ? pe_ctrl_pkg::st_opsum : pe_ctrl_pkg::st_op;
            end
            pe_ctrl_pkg::st_op: begin
                next_state = op_last ? pe_ctrl_pkg::st_drain : pe_ctrl_pkg::st_op;
            end
            pe_ctrl_pkg::st_drain: begin
                next_state = drain_last ? pe_ctrl_pkg::st_opsum : pe_ctrl_pkg::st_drain;
            end
            pe_ctrl_pkg::st_opsum: begin
                next_state = free ? pe_ctrl_pkg::st_idle : pe_ctrl_pkg::st_opsum;
            end
            default: begin
                next_state = pe_ctrl_pkg::st_idle;
            end
        endcase
    end

    assign busy       = (state != pe_ctrl_pkg::st_idle);
    assign rd_en      = (state == pe_ctrl_pkg::st_op);
    assign rd_addr    = cnt;
    assign load_ipsum = (state == pe_ctrl_pkg::st_ipsum);  // single cycle state
    assign post       = (state == pe_ctrl_pkg::st_opsum) && free;

    a_addr_range: assert property (
        @(posedge clk) disable iff (!rstn)
        rd_en |-> ({1'b0, rd_addr} < k_sq)
    );

    // source must still hold req when the ack becomes visible
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(start_ack) |-> start_req
    );

endmodule

`default_nettype wire

// File: rtl/pe_spad.sv
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module pe_spad (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wr_en,
    input  pe_data_pkg::spad_addr_t wr_addr,
    input  pe_data_pkg::act_t       wr_act,
    input  pe_data_pkg::wgt_t       wr_wgt,
    input  logic                    rd_en,
    input  pe_data_pkg::spad_addr_t rd_addr,
    output pe_data_pkg::act_t       rd_act,
    output pe_data_pkg::wgt_t       rd_wgt,
    output logic                    rd_valid
);

    pe_data_pkg::act_t act_mem [`PE_SPAD_DEPTH];  // activation half of each entry
    pe_data_pkg::wgt_t wgt_mem [`PE_SPAD_DEPTH];  // weight half, same address

    always_ff @(posedge clk) begin
        if (wr_en) begin
            act_mem[wr_addr] <= wr_act;
            wgt_mem[wr_addr] <= wr_wgt;
        end
    end

    // registered read, one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_act <= act_mem[rd_addr];
            rd_wgt <= wgt_mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;  // qualifies rd_act/rd_wgt
        end
    end

    // external writes are blocked while a job reads the array
    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (!rstn)
        !(rd_en && wr_en)
    );

endmodule

`default_nettype wire

// File: rtl/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_ipsum,   // load ipsum into the accumulator
        st_op,      // one scratchpad read per cycle
        st_drain,   // let the pipeline empty
        st_opsum    // hand result to the port
    } pe_state_t;

endpackage

`default_nettype wire

// File: rtl/pe_data_pkg.sv
`default_nettype none
`include "pe_macros.svh"

package pe_data_pkg;

    typedef logic signed [`PE_ACT_W-1:0]  act_t;   // activation
    typedef logic signed [`PE_WGT_W-1:0]  wgt_t;   // weight
    typedef logic signed [`PE_PROD_W-1:0] prod_t;  // act * wgt
    typedef logic signed [`PE_PSUM_W-1:0] psum_t;  // wraps mod 2^24

    typedef logic [`PE_ADDR_W-1:0]  spad_addr_t;
    typedef logic [`PE_KSIZE_W-1:0] ksize_t;       // unclamped job size

endpackage

`default_nettype wire

// File: rtl/pe_macros.svh
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// operand and result widths
`define PE_ACT_W        8
`define PE_WGT_W        8
`define PE_PROD_W       16
`define PE_PSUM_W       24

// kernel side is clamped to this value
`define PE_MAX_KERNEL   8
`define PE_KSIZE_W      4

// scratchpad holds one full kernel window
`define PE_SPAD_DEPTH   64
`define PE_ADDR_W       6

// read stage plus product stage
`define PE_DRAIN        2

`endif
